/* design/rbcp_read_pkg.sv */
package rbcp_read_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    localparam int RBCP_ADDR_W   = 32;
    localparam int RBCP_DATA_W   = 8;
    localparam int SYSMON_W      = 12;
    // temperature, vccint, vccaux, vccbram, vpvn, vrefp, vrefn
    localparam int SYSMON_CH     = 7;
    localparam int INJECT_ADDR_W = 40;
    localparam int SEU_COUNT_W   = 16;

    //////////////////////////////
    // Page base addresses
    //////////////////////////////

    localparam logic [RBCP_ADDR_W-1:0] INJECT_BASE = 32'h0000_0010;
    localparam logic [RBCP_ADDR_W-1:0] CONFIG_BASE = 32'h0000_0110;
    localparam logic [RBCP_ADDR_W-1:0] SEU_BASE    = 32'h0000_0120;
    // Monitor reset then two bytes per channel
    localparam logic [RBCP_ADDR_W-1:0] SYSMON_BASE = 32'h0000_0130;

    //////////////////////////////
    // Bus types
    //////////////////////////////

    typedef struct packed {
        logic                   valid;
        logic [RBCP_ADDR_W-1:0] addr;
    } rbcp_req_t;

    // Data is zero on a miss
    typedef struct packed {
        logic                   hit;
        logic [RBCP_DATA_W-1:0] data;
    } read_hit_t;

    //////////////////////////////
    // Status words
    //////////////////////////////

    typedef struct packed {
        logic                     start;
        logic [2:0]               strobe_sel;
        logic [INJECT_ADDR_W-1:0] inject_addr;
    } inject_status_t;

    typedef struct packed {
        logic [3:0]  trigger_mode;
        logic        drs_mode;
        logic        auto_reset;
        logic        drs_load;
        // ASD threshold
        logic [11:0] thre_value;
        logic        sync_start;
        logic [7:0]  adc_latency;
        logic [2:0]  adc_clk_select;
        logic [2:0]  test_in_divide;
        logic [7:0]  test_in_length;
        logic [3:0]  spare;
    } run_config_t;

    typedef struct packed {
        logic [SEU_COUNT_W-1:0]                seu_enable_count;
        logic [SEU_COUNT_W-1:0]                seu_disable_count;
        logic                                  seu_count_reset;
        logic [7:0]                            seu_rx;
        logic                                  seu_send_command;
        logic                                  monitor_rst;
        // Index 0 is temperature
        logic [SYSMON_CH-1:0][SYSMON_W-1:0]    sysmon;
    } monitor_status_t;

endpackage

/* design/rbcp_read_capture.sv */
module rbcp_read_capture
(
    input  logic                                    CLK,
    input  logic                                    reset,
    input  logic                                    rbcp_act,
    input  logic                                    rbcp_re,
    input  logic [rbcp_read_pkg::RBCP_ADDR_W-1:0]   rbcp_addr,
    output rbcp_read_pkg::rbcp_req_t                req
);

    logic read_strobe;

    assign read_strobe = rbcp_act && rbcp_re;

    // Idle cycles carry address zero
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            req <= '0;
        end
        else if (read_strobe)
        begin
            req.valid <= 1'b1;
            req.addr  <= rbcp_addr;
        end
        else
        begin
            req <= '0;
        end
    end

endmodule

/* design/inject_status_page.sv */
module inject_status_page
(
    input  rbcp_read_pkg::rbcp_req_t        req,
    input  rbcp_read_pkg::inject_status_t   inject,
    output rbcp_read_pkg::read_hit_t        result
);

    logic [rbcp_read_pkg::RBCP_ADDR_W-1:0] offset;
    logic [2:0]                             byte_sel;

    assign offset   = req.addr - rbcp_read_pkg::INJECT_BASE;
    // Address bytes from offset 2 with the MSB first
    assign byte_sel = offset[2:0] - 3'd2;

    always_comb
    begin
        result = '0;
        if (req.valid && offset < 2 + rbcp_read_pkg::INJECT_ADDR_W / 8)
        begin
            result.hit = 1'b1;
            case (offset[2:0])
                3'd0:    result.data = {7'h0, inject.start};
                3'd1:    result.data = {5'h0, inject.strobe_sel};
                default:
                begin
                    result.data = inject.inject_addr[
                        rbcp_read_pkg::INJECT_ADDR_W - 8 - 8 * byte_sel +: 8];
                end
            endcase
        end
    end

endmodule

/* design/run_config_page.sv */
module run_config_page
(
    input  rbcp_read_pkg::rbcp_req_t    req,
    input  rbcp_read_pkg::run_config_t  run_config,
    output rbcp_read_pkg::read_hit_t    result
);

    logic [rbcp_read_pkg::RBCP_ADDR_W-1:0] offset;

    assign offset = req.addr - rbcp_read_pkg::CONFIG_BASE;

    always_comb
    begin
        result = '0;
        if (req.valid && offset < 16)
        begin
            result.hit = 1'b1;
            case (offset[3:0])
                4'h0: result.data = {7'h0, run_config.auto_reset};
                4'h1: result.data = {7'h0, run_config.drs_load};
                // ASD threshold high nibble then low byte
                4'h5: result.data = {4'h0, run_config.thre_value[11:8]};
                4'h6: result.data = run_config.thre_value[7:0];
                4'h9: result.data = {7'h0, run_config.sync_start};
                4'hA: result.data = run_config.adc_latency;
                4'hB: result.data = {5'h0, run_config.adc_clk_select};
                4'hC: result.data = {5'h0, run_config.test_in_divide};
                4'hD:
                begin
                    result.data = {3'h0, run_config.drs_mode, run_config.trigger_mode};
                end
                4'hE: result.data = run_config.test_in_length;
                default:
                begin
                    // Gaps in the page
                    result.hit  = 1'b0;
                    result.data = '0;
                end
            endcase
        end
    end

endmodule

/* design/monitor_status_page.sv */
module monitor_status_page
(
    input  rbcp_read_pkg::rbcp_req_t        req,
    input  rbcp_read_pkg::monitor_status_t  monitor,
    output rbcp_read_pkg::read_hit_t        result
);

    logic [rbcp_read_pkg::RBCP_ADDR_W-1:0] seu_offset;
    logic [rbcp_read_pkg::RBCP_ADDR_W-1:0] sm_offset;
    logic [3:0]                             sm_step;
    logic [rbcp_read_pkg::SYSMON_W-1:0]    sample;

    assign seu_offset = req.addr - rbcp_read_pkg::SEU_BASE;
    assign sm_offset  = req.addr - rbcp_read_pkg::SYSMON_BASE;
    // Channel k sits at offsets 2k+1 and 2k+2
    assign sm_step    = sm_offset[3:0] - 4'd1;

    always_comb
    begin
        result = '0;
        sample = '0;
        if (req.valid && seu_offset < 7)
        begin
            result.hit = 1'b1;
            case (seu_offset[2:0])
                3'd0:    result.data = monitor.seu_enable_count[15:8];
                3'd1:    result.data = monitor.seu_enable_count[7:0];
                3'd2:    result.data = monitor.seu_disable_count[15:8];
                3'd3:    result.data = monitor.seu_disable_count[7:0];
                3'd4:    result.data = {7'h0, monitor.seu_count_reset};
                3'd5:    result.data = monitor.seu_rx;
                default: result.data = {7'h0, monitor.seu_send_command};
            endcase
        end
        else if (req.valid && sm_offset == 0)
        begin
            result.hit  = 1'b1;
            result.data = {7'h0, monitor.monitor_rst};
        end
        else if (req.valid && sm_offset <= 2 * rbcp_read_pkg::SYSMON_CH)
        begin
            result.hit = 1'b1;
            sample     = monitor.sysmon[sm_step[3:1]];
            // Odd offset is the high nibble
            if (sm_offset[0])
            begin
                result.data = {4'h0, sample[11:8]};
            end
            else
            begin
                result.data = sample[7:0];
            end
        end
    end

endmodule

/* design/read_response.sv */
module read_response
(
    input  logic                                    CLK,
    input  logic                                    reset,
    input  rbcp_read_pkg::read_hit_t                inject_result,
    input  rbcp_read_pkg::read_hit_t                config_result,
    input  rbcp_read_pkg::read_hit_t                monitor_result,
    output logic [rbcp_read_pkg::RBCP_DATA_W-1:0]   rbcp_rd,
    output logic                                    rbcp_ack
);

    logic                                   any_hit;
    logic [rbcp_read_pkg::RBCP_DATA_W-1:0] hit_data;

    assign any_hit = inject_result.hit || config_result.hit || monitor_result.hit;

    always_comb
    begin
        hit_data = '0;
        if (inject_result.hit)
            hit_data = inject_result.data;
        else if (config_result.hit)
            hit_data = config_result.data;
        else if (monitor_result.hit)
            hit_data = monitor_result.data;
    end

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            rbcp_ack <= 1'b0;
            rbcp_rd  <= '0;
        end
        else
        begin
            rbcp_ack <= any_hit;
            rbcp_rd  <= hit_data;
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    // Page maps must not overlap
    a_one_page_hit: assert property (@(posedge CLK) disable iff (reset)
        $onehot0({inject_result.hit, config_result.hit, monitor_result.hit}));

    // Bus data stays quiet between answers
    a_idle_data_zero: assert property (@(posedge CLK)
        !rbcp_ack |-> rbcp_rd == '0);

endmodule

/* design/rbcp_read.sv */
module rbcp_read
(
    input  logic                                    CLK,
    input  logic                                    reset,
    input  logic                                    rbcp_act,
    input  logic                                    rbcp_re,
    input  logic [rbcp_read_pkg::RBCP_ADDR_W-1:0]   rbcp_addr,
    input  rbcp_read_pkg::inject_status_t           inject,
    input  rbcp_read_pkg::run_config_t              run_config,
    input  rbcp_read_pkg::monitor_status_t          monitor,
    output logic [rbcp_read_pkg::RBCP_DATA_W-1:0]   rbcp_rd,
    output logic                                    rbcp_ack
);

    rbcp_read_pkg::rbcp_req_t   req;
    rbcp_read_pkg::read_hit_t   inject_result;
    rbcp_read_pkg::read_hit_t   config_result;
    rbcp_read_pkg::read_hit_t   monitor_result;

    rbcp_read_capture i_capture (
        .CLK       (CLK),
        .reset     (reset),
        .rbcp_act  (rbcp_act),
        .rbcp_re   (rbcp_re),
        .rbcp_addr (rbcp_addr),
        .req       (req)
    );

    // Register pages
    inject_status_page i_inject_page (
        .req    (req),
        .inject (inject),
        .result (inject_result)
    );

    run_config_page i_config_page (
        .req        (req),
        .run_config (run_config),
        .result     (config_result)
    );

    monitor_status_page i_monitor_page (
        .req     (req),
        .monitor (monitor),
        .result  (monitor_result)
    );

    read_response i_response (
        .CLK            (CLK),
        .reset          (reset),
        .inject_result  (inject_result),
        .config_result  (config_result),
        .monitor_result (monitor_result),
        .rbcp_rd        (rbcp_rd),
        .rbcp_ack       (rbcp_ack)
    );

endmodule

/* testbench/tb_rbcp_read.sv */
module tb_rbcp_read;

    localparam int SEED           = 32'h5d3e;
    localparam int TIMEOUT_CYCLES = 50;

    typedef struct packed {
        logic        tracked;
        logic [31:0] addr;
        logic        hit;
        logic [7:0]  data;
    } expected_t;

    logic                                   CLK;
    logic                                   reset;
    logic                                   rbcp_act;
    logic                                   rbcp_re;
    logic [rbcp_read_pkg::RBCP_ADDR_W-1:0]  rbcp_addr;
    rbcp_read_pkg::inject_status_t          inject;
    rbcp_read_pkg::run_config_t             run_config;
    rbcp_read_pkg::monitor_status_t         monitor;
    logic [rbcp_read_pkg::RBCP_DATA_W-1:0]  rbcp_rd;
    logic                                   rbcp_ack;

    expected_t pending [$];
    int        outstanding = 0;
    int        checks = 0;
    int        check_errors = 0;
    int        flow_errors = 0;
    int        tests_run = 0;
    int        tests_failed = 0;
    int        error_mark = 0;
    string     test_name;

    rbcp_read i_dut (
        .CLK        (CLK),
        .reset      (reset),
        .rbcp_act   (rbcp_act),
        .rbcp_re    (rbcp_re),
        .rbcp_addr  (rbcp_addr),
        .inject     (inject),
        .run_config (run_config),
        .monitor    (monitor),
        .rbcp_rd    (rbcp_rd),
        .rbcp_ack   (rbcp_ack)
    );

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    //////////////////////////////
    // Reference address map
    //////////////////////////////

    function automatic rbcp_read_pkg::read_hit_t expected_read(
        input logic [31:0]                    addr,
        input rbcp_read_pkg::inject_status_t  inj,
        input rbcp_read_pkg::run_config_t     cfg,
        input rbcp_read_pkg::monitor_status_t mon);
        rbcp_read_pkg::read_hit_t res;
        logic [31:0]              step;
        logic [11:0]              sample;
        res.hit  = 1'b1;
        res.data = 8'h00;
        case (addr)
            32'h010: res.data = {7'h0, inj.start};
            32'h011: res.data = {5'h0, inj.strobe_sel};
            32'h012: res.data = inj.inject_addr[39:32];
            32'h013: res.data = inj.inject_addr[31:24];
            32'h014: res.data = inj.inject_addr[23:16];
            32'h015: res.data = inj.inject_addr[15:8];
            32'h016: res.data = inj.inject_addr[7:0];
            32'h110: res.data = {7'h0, cfg.auto_reset};
            32'h111: res.data = {7'h0, cfg.drs_load};
            32'h115: res.data = {4'h0, cfg.thre_value[11:8]};
            32'h116: res.data = cfg.thre_value[7:0];
            32'h119: res.data = {7'h0, cfg.sync_start};
            32'h11A: res.data = cfg.adc_latency;
            32'h11B: res.data = {5'h0, cfg.adc_clk_select};
            32'h11C: res.data = {5'h0, cfg.test_in_divide};
            32'h11D: res.data = {3'h0, cfg.drs_mode, cfg.trigger_mode};
            32'h11E: res.data = cfg.test_in_length;
            32'h120: res.data = mon.seu_enable_count[15:8];
            32'h121: res.data = mon.seu_enable_count[7:0];
            32'h122: res.data = mon.seu_disable_count[15:8];
            32'h123: res.data = mon.seu_disable_count[7:0];
            32'h124: res.data = {7'h0, mon.seu_count_reset};
            32'h125: res.data = mon.seu_rx;
            32'h126: res.data = {7'h0, mon.seu_send_command};
            32'h130: res.data = {7'h0, mon.monitor_rst};
            default:
            begin
                if (addr >= 32'h131 && addr <= 32'h13E)
                begin
                    // Two addresses per channel with the high nibble first
                    step     = addr - 32'h131;
                    sample   = mon.sysmon[step[3:1]];
                    res.data = step[0] ? sample[7:0] : {4'h0, sample[11:8]};
                end
                else
                    res = '0;
            end
        endcase
        return res;
    endfunction

    //////////////////////////////
    // Response checker
    //////////////////////////////

    task automatic compare_response(input expected_t want);
        checks++;
        if (rbcp_ack !== want.hit)
        begin
            check_errors++;
            $display("Error: rbcp_ack for addr %h is %h, expected %h",
                     want.addr, rbcp_ack, want.hit);
        end
        if (rbcp_rd !== want.data)
        begin
            check_errors++;
            $display("Error: rbcp_rd for addr %h is %h, expected %h",
                     want.addr, rbcp_rd, want.data);
        end
        if (want.hit && want.addr >= 32'h131 && want.addr <= 32'h13E && want.addr[0]
            && rbcp_rd > 8'h0F)
        begin
            check_errors++;
            $display("Error: rbcp_rd sysmon high byte at addr %h is %h, above 0f",
                     want.addr, rbcp_rd);
        end
        if (want.tracked)
            outstanding--;
    endtask

    // Outputs at this edge answer the inputs driven two edges ago
    always @(negedge CLK)
    begin : response_check
        expected_t                entry;
        rbcp_read_pkg::read_hit_t ref_hit;
        if (reset)
        begin
            pending.delete();
            outstanding = 0;
        end
        else
        begin
            if (pending.size() == 2)
                compare_response(pending.pop_front());
            entry      = '0;
            entry.addr = rbcp_addr;
            if (rbcp_act || rbcp_re)
            begin
                entry.tracked = 1'b1;
                outstanding++;
            end
            if (rbcp_act && rbcp_re)
            begin
                ref_hit    = expected_read(rbcp_addr, inject, run_config, monitor);
                entry.hit  = ref_hit.hit;
                entry.data = ref_hit.data;
            end
            pending.push_back(entry);
        end
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    task automatic finish_run();
        int total;
        total = check_errors + flow_errors;
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, total);
        if (total == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic begin_test(input string name);
        test_name  = name;
        error_mark = check_errors + flow_errors;
    endtask

    task automatic end_test();
        int found;
        found = check_errors + flow_errors - error_mark;
        tests_run++;
        if (found == 0)
            $display("Test %s: ok", test_name);
        else
        begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", test_name, found);
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (outstanding != 0 && cycles < TIMEOUT_CYCLES)
        begin
            @(posedge CLK);
            cycles++;
        end
        if (outstanding != 0)
        begin
            flow_errors++;
            $display("Timeout: %0d responses still pending after %0d cycles in test %s",
                     outstanding, cycles, test_name);
        end
    endtask

    task automatic issue_read(input logic [31:0] addr);
        @(posedge CLK);
        rbcp_act  <= 1'b1;
        rbcp_re   <= 1'b1;
        rbcp_addr <= addr;
    endtask

    task automatic go_idle();
        @(posedge CLK);
        rbcp_act  <= 1'b0;
        rbcp_re   <= 1'b0;
        rbcp_addr <= '0;
    endtask

    task automatic read_one(input logic [31:0] addr);
        issue_read(addr);
        go_idle();
        wait_drain();
    endtask

    task automatic read_range(input logic [31:0] first, input logic [31:0] last);
        for (logic [31:0] a = first; a <= last; a++)
            read_one(a);
    endtask

    task automatic randomize_status();
        logic [127:0] bits;
        @(posedge CLK);
        bits = {$urandom, $urandom, $urandom, $urandom};
        inject <= bits[$bits(rbcp_read_pkg::inject_status_t)-1:0];
        bits = {$urandom, $urandom, $urandom, $urandom};
        run_config <= bits[$bits(rbcp_read_pkg::run_config_t)-1:0];
        bits = {$urandom, $urandom, $urandom, $urandom};
        monitor <= bits[$bits(rbcp_read_pkg::monitor_status_t)-1:0];
    endtask

    // Mostly page addresses and some fully random ones
    function automatic logic [31:0] random_addr();
        logic [31:0] r;
        r = $urandom;
        case (r[1:0])
            2'd0:    return 32'h010 + {29'h0, r[4:2]};
            2'd1:    return 32'h110 + {28'h0, r[5:2]};
            2'd2:    return 32'h120 + {27'h0, r[6:2]};
            default: return $urandom;
        endcase
    endfunction

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial
    begin
        void'($urandom(SEED));
        reset      <= 1'b1;
        rbcp_act   <= 1'b0;
        rbcp_re    <= 1'b0;
        rbcp_addr  <= '0;
        inject     <= '0;
        run_config <= '0;
        monitor    <= '0;
        repeat (2) @(posedge CLK);
        reset <= 1'b0;

        begin_test("reset");
        @(negedge CLK);
        if (rbcp_ack !== 1'b0)
        begin
            flow_errors++;
            $display("Error: rbcp_ack after reset is %h, expected 0", rbcp_ack);
        end
        if (rbcp_rd !== 8'h00)
        begin
            flow_errors++;
            $display("Error: rbcp_rd after reset is %h, expected 00", rbcp_rd);
        end
        // Activity without read enable
        @(posedge CLK);
        rbcp_act  <= 1'b1;
        rbcp_re   <= 1'b0;
        rbcp_addr <= 32'h010;
        go_idle();
        wait_drain();
        end_test();

        begin_test("injection page");
        randomize_status();
        read_range(32'h010, 32'h016);
        end_test();

        begin_test("run configuration page");
        randomize_status();
        read_range(32'h110, 32'h11E);
        end_test();

        begin_test("monitor page");
        randomize_status();
        read_range(32'h120, 32'h126);
        read_range(32'h130, 32'h13E);
        end_test();

        begin_test("unmapped addresses");
        read_one(32'h117);
        read_one(32'h200);
        read_one(32'h300);
        read_one(32'h112);
        read_one(32'h12F);
        read_one(32'h10010);
        end_test();

        begin_test("back-to-back burst");
        randomize_status();
        repeat (40) issue_read(random_addr());
        go_idle();
        wait_drain();
        end_test();

        finish_run();
    end

endmodule

/* files.f */
design/rbcp_read_pkg.sv
design/rbcp_read_capture.sv
design/inject_status_page.sv
design/run_config_page.sv
design/monitor_status_page.sv
design/read_response.sv
design/rbcp_read.sv
testbench/tb_rbcp_read.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rbcp_read
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuild only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)
